// ==== hdl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define WORD_W      32
`define REG_ADDR_W  5
`define RESET_PC    32'h0000_0000

// the only two opcodes this core executes
`define OPC_OP_IMM  7'b0010011
`define OPC_OP      7'b0110011

`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLL     4'd2
`define ALU_SLT     4'd3
`define ALU_SLTU    4'd4
`define ALU_XOR     4'd5
`define ALU_SRL     4'd6
`define ALU_SRA     4'd7
`define ALU_OR      4'd8
`define ALU_AND     4'd9

`endif

// ==== hdl/cpu_pkg.sv ====
`include "cpu_consts.svh"

package cpu_pkg;

    // data word, also used for instructions and pc values
    typedef logic [`WORD_W-1:0] word_t;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [3:0] alu_op_t;

endpackage

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t inst_data,
    output word_t inst_addr,
    output logic  inst_en,
    output word_t if_pc,
    output word_t if_inst
);

    word_t pc;

    assign inst_addr = pc;

    // the pc only moves once fetching has been enabled
    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= `RESET_PC;
            inst_en <= 1'b0;
        end else begin
            inst_en <= 1'b1;
            if (inst_en) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // a zero word in if_inst is a bubble for decode
    always_ff @(posedge clk) begin
        if (rst) begin
            if_inst <= '0;
        end else begin
            if_inst <= inst_en ? inst_data : '0;
        end
    end

    always_ff @(posedge clk) begin
        if_pc <= pc;
    end

    a_addr_aligned: assert property (@(posedge clk) disable iff (rst)
        inst_en |-> (inst_addr[1:0] == 2'b00));

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      re1,
    input  logic      re2,
    input  reg_addr_t addr1,
    input  reg_addr_t addr2,
    output word_t     data1,
    output word_t     data2,
    input  logic      we,
    input  reg_addr_t wa,
    input  word_t     wd
);

    // x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // same-cycle writes are covered by forwarding in decode, so no bypass here
    always_comb begin
        data1 = '0;
        data2 = '0;
        if (re1 && addr1 != '0) begin
            data1 = regs[addr1];
        end
        if (re2 && addr2 != '0) begin
            data2 = regs[addr2];
        end
    end

    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        we |-> (wa != '0));

endmodule

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     if_pc,
    input  word_t     if_inst,
    output logic      rf_re1,
    output logic      rf_re2,
    output reg_addr_t rf_addr1,
    output reg_addr_t rf_addr2,
    input  word_t     rf_data1,
    input  word_t     rf_data2,
    input  word_t     ex_result,
    input  reg_addr_t ex_wa,
    input  logic      ex_we,
    input  word_t     wb_data,
    input  reg_addr_t wb_wa,
    input  logic      wb_we,
    output word_t     id_pc,
    output alu_op_t   id_alu_op,
    output word_t     id_op1,
    output word_t     id_op2,
    output reg_addr_t id_wa,
    output logic      id_we
);

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      imm;
    word_t      shamt;
    logic       valid;
    logic       use_rs2;
    logic       use_shamt;
    alu_op_t    alu_op;
    word_t      op1;
    word_t      op2;

    assign opcode = if_inst[6:0];
    assign rd     = if_inst[11:7];
    assign funct3 = if_inst[14:12];
    assign rs1    = if_inst[19:15];
    assign rs2    = if_inst[24:20];
    assign funct7 = if_inst[31:25];
    assign alt    = if_inst[30];
    assign imm    = {{20{if_inst[31]}}, if_inst[31:20]};
    assign shamt  = {27'b0, if_inst[24:20]};

    // anything not recognized here leaves valid low and travels as a bubble
    always_comb begin
        valid     = 1'b0;
        use_rs2   = 1'b0;
        use_shamt = 1'b0;
        alu_op    = `ALU_ADD;
        case (opcode)
            `OPC_OP_IMM: begin
                valid = 1'b1;
                case (funct3)
                    `F3_ADD:  alu_op = `ALU_ADD;
                    `F3_SLT:  alu_op = `ALU_SLT;
                    `F3_SLTU: alu_op = `ALU_SLTU;
                    `F3_XOR:  alu_op = `ALU_XOR;
                    `F3_OR:   alu_op = `ALU_OR;
                    `F3_AND:  alu_op = `ALU_AND;
                    `F3_SLL: begin
                        alu_op    = `ALU_SLL;
                        use_shamt = 1'b1;
                        valid     = (funct7 == F7_BASE);
                    end
                    `F3_SR: begin
                        alu_op    = alt ? `ALU_SRA : `ALU_SRL;
                        use_shamt = 1'b1;
                        valid     = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                    default: valid = 1'b0;
                endcase
            end
            `OPC_OP: begin
                use_rs2 = 1'b1;
                valid   = (funct7 == F7_BASE);
                case (funct3)
                    `F3_ADD: begin
                        alu_op = alt ? `ALU_SUB : `ALU_ADD;
                        valid  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                    `F3_SR: begin
                        alu_op = alt ? `ALU_SRA : `ALU_SRL;
                        valid  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    end
                    `F3_SLL:  alu_op = `ALU_SLL;
                    `F3_SLT:  alu_op = `ALU_SLT;
                    `F3_SLTU: alu_op = `ALU_SLTU;
                    `F3_XOR:  alu_op = `ALU_XOR;
                    `F3_OR:   alu_op = `ALU_OR;
                    `F3_AND:  alu_op = `ALU_AND;
                    default:  valid = 1'b0;
                endcase
            end
            default: valid = 1'b0;
        endcase
    end

    assign rf_re1   = valid;
    assign rf_re2   = valid && use_rs2;
    assign rf_addr1 = rs1;
    assign rf_addr2 = rs2;

    // the younger result in execute wins over writeback
    function automatic word_t forward(input reg_addr_t addr, input word_t rf_val);
        if (ex_we && ex_wa == addr) begin
            return ex_result;
        end else if (wb_we && wb_wa == addr) begin
            return wb_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        op1 = forward(rs1, rf_data1);
        op2 = use_rs2 ? forward(rs2, rf_data2) : (use_shamt ? shamt : imm);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_we     <= 1'b0;
            id_wa     <= '0;
            id_alu_op <= `ALU_ADD;
        end else begin
            // x0 is never written, so the enable drops here
            id_we     <= valid && (rd != '0);
            id_wa     <= rd;
            id_alu_op <= alu_op;
        end
    end

    always_ff @(posedge clk) begin
        id_pc  <= if_pc;
        id_op1 <= op1;
        id_op2 <= op2;
    end

    a_wa_nonzero: assert property (@(posedge clk) disable iff (rst)
        id_we |-> (id_wa != '0));

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module execute_stage import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_t     id_pc,
    input  alu_op_t   id_alu_op,
    input  word_t     id_op1,
    input  word_t     id_op2,
    input  reg_addr_t id_wa,
    input  logic      id_we,
    output word_t     ex_result,
    output word_t     wb_pc,
    output reg_addr_t wb_wa,
    output word_t     wb_data,
    output logic      wb_we
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = id_op2[4:0];
    assign lt_signed   = $signed(id_op1) < $signed(id_op2);
    assign lt_unsigned = id_op1 < id_op2;

    always_comb begin
        case (id_alu_op)
            `ALU_ADD:  ex_result = id_op1 + id_op2;
            `ALU_SUB:  ex_result = id_op1 - id_op2;
            `ALU_SLL:  ex_result = id_op1 << shamt;
            `ALU_SLT:  ex_result = {31'b0, lt_signed};
            `ALU_SLTU: ex_result = {31'b0, lt_unsigned};
            `ALU_XOR:  ex_result = id_op1 ^ id_op2;
            `ALU_SRL:  ex_result = id_op1 >> shamt;
            `ALU_SRA:  ex_result = word_t'($signed(id_op1) >>> shamt);
            `ALU_OR:   ex_result = id_op1 | id_op2;
            `ALU_AND:  ex_result = id_op1 & id_op2;
            default:   ex_result = '0;
        endcase
    end

    // the writeback register also feeds the register file write port
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we <= 1'b0;
            wb_wa <= '0;
        end else begin
            wb_we <= id_we;
            wb_wa <= id_wa;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc   <= id_pc;
        wb_data <= ex_result;
    end

    a_alu_op_known: assert property (@(posedge clk) disable iff (rst)
        id_we |-> (id_alu_op inside {`ALU_ADD, `ALU_SUB, `ALU_SLL, `ALU_SLT, `ALU_SLTU,
                                     `ALU_XOR, `ALU_SRL, `ALU_SRA, `ALU_OR, `ALU_AND}));

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    output word_t     inst_addr,
    output logic      inst_en,
    input  word_t     inst_data,
    output logic      retire_we,
    output word_t     retire_pc,
    output reg_addr_t retire_addr,
    output word_t     retire_data
);

    word_t     if_pc;
    word_t     if_inst;
    logic      rf_re1;
    logic      rf_re2;
    reg_addr_t rf_addr1;
    reg_addr_t rf_addr2;
    word_t     rf_data1;
    word_t     rf_data2;
    word_t     id_pc;
    alu_op_t   id_alu_op;
    word_t     id_op1;
    word_t     id_op2;
    reg_addr_t id_wa;
    logic      id_we;
    word_t     ex_result;

    fetch_stage i_fetch (
        .clk       (clk),
        .rst       (rst),
        .inst_data (inst_data),
        .inst_addr (inst_addr),
        .inst_en   (inst_en),
        .if_pc     (if_pc),
        .if_inst   (if_inst)
    );

    // the retirement port is the writeback register itself
    decode_stage i_decode (
        .clk       (clk),
        .rst       (rst),
        .if_pc     (if_pc),
        .if_inst   (if_inst),
        .rf_re1    (rf_re1),
        .rf_re2    (rf_re2),
        .rf_addr1  (rf_addr1),
        .rf_addr2  (rf_addr2),
        .rf_data1  (rf_data1),
        .rf_data2  (rf_data2),
        .ex_result (ex_result),
        .ex_wa     (id_wa),
        .ex_we     (id_we),
        .wb_data   (retire_data),
        .wb_wa     (retire_addr),
        .wb_we     (retire_we),
        .id_pc     (id_pc),
        .id_alu_op (id_alu_op),
        .id_op1    (id_op1),
        .id_op2    (id_op2),
        .id_wa     (id_wa),
        .id_we     (id_we)
    );

    reg_file i_reg_file (
        .clk   (clk),
        .rst   (rst),
        .re1   (rf_re1),
        .re2   (rf_re2),
        .addr1 (rf_addr1),
        .addr2 (rf_addr2),
        .data1 (rf_data1),
        .data2 (rf_data2),
        .we    (retire_we),
        .wa    (retire_addr),
        .wd    (retire_data)
    );

    execute_stage i_execute (
        .clk       (clk),
        .rst       (rst),
        .id_pc     (id_pc),
        .id_alu_op (id_alu_op),
        .id_op1    (id_op1),
        .id_op2    (id_op2),
        .id_wa     (id_wa),
        .id_we     (id_we),
        .ex_result (ex_result),
        .wb_pc     (retire_pc),
        .wb_wa     (retire_addr),
        .wb_data   (retire_data),
        .wb_we     (retire_we)
    );

endmodule

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int MEM_WORDS = 256;
    localparam logic [31:0] LFSR_MASK = 32'h8020_0003;

    logic      clk;
    logic      rst;
    word_t     inst_addr;
    logic      inst_en;
    word_t     inst_data;
    logic      retire_we;
    word_t     retire_pc;
    reg_addr_t retire_addr;
    word_t     retire_data;

    word_t       imem [0:MEM_WORDS-1];
    word_t       model_regs [0:31];
    word_t       prog [$];
    word_t       exp_pc [$];
    reg_addr_t   exp_rd [$];
    word_t       exp_val [$];
    word_t       pc_hist [$];
    logic [31:0] lfsr;

    // instruction memory answers in the same cycle, words past the end read as bubbles
    assign inst_data = (inst_addr < 32'(MEM_WORDS * 4)) ? imem[inst_addr[9:2]] : '0;

    cpu_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .inst_addr   (inst_addr),
        .inst_en     (inst_en),
        .inst_data   (inst_data),
        .retire_we   (retire_we),
        .retire_pc   (retire_pc),
        .retire_addr (retire_addr),
        .retire_data (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg_addr(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got x%0d expected x%0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // galois lfsr, one step per bit handed out
    function automatic word_t rand_bits(input int n);
        word_t r;
        logic  b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? LFSR_MASK : 32'h0);
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic word_t enc_i(input logic [2:0] f3, input reg_addr_t rd,
                                    input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    // reference model applying RV32I semantics, queues every write to a nonzero rd
    task automatic model_exec(input word_t inst, input word_t pc);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      res;
        logic       ok;
        logic       alt;
        opc = inst[6:0];
        f3  = inst[14:12];
        f7  = inst[31:25];
        rd  = inst[11:7];
        a   = model_regs[inst[19:15]];
        b   = '0;
        res = '0;
        ok  = 1'b0;
        alt = 1'b0;
        if (opc == `OPC_OP_IMM) begin
            b   = {{20{inst[31]}}, inst[31:20]};
            ok  = 1'b1;
            alt = (f3 == `F3_SR) && (f7 == 7'h20);
            if (f3 == `F3_SLL || f3 == `F3_SR) begin
                b  = {27'b0, inst[24:20]};
                ok = (f7 == 7'h00) || alt;
            end
        end else if (opc == `OPC_OP) begin
            b   = model_regs[inst[24:20]];
            alt = (f7 == 7'h20);
            ok  = (f7 == 7'h00) || (alt && (f3 == `F3_ADD || f3 == `F3_SR));
        end
        case (f3)
            `F3_ADD:  res = alt ? a - b : a + b;
            `F3_SLL:  res = a << b[4:0];
            `F3_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            `F3_XOR:  res = a ^ b;
            `F3_SR:   res = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            `F3_OR:   res = a | b;
            default:  res = a & b;
        endcase
        if (ok && rd != 5'd0) begin
            model_regs[rd] = res;
            exp_pc.push_back(pc);
            exp_rd.push_back(rd);
            exp_val.push_back(res);
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        #1 rst = 1'b1;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_flag(inst_en, 1'b0, "inst_en during reset");
                check_flag(retire_we, 1'b0, "retire_we during reset");
            end
            @(posedge clk);
        end
        #1 rst = 1'b0;
    endtask

    // fetch has to start in the first cycle after reset is released
    task automatic wait_fetch_start();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!inst_en) begin
            if (waited == 1) begin
                $display("fetch did not start in the first cycle after reset");
                abort_run();
            end
            waited++;
            @(negedge clk);
        end
    endtask

    // loads prog, resets the DUT and checks every retirement against the model
    task automatic run_program(input string name);
        int cycles;
        int limit;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : '0;
        end
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        exp_pc.delete();
        exp_rd.delete();
        exp_val.delete();
        pc_hist.delete();
        for (int i = 0; i < prog.size(); i++) begin
            model_exec(prog[i], word_t'(4 * i));
        end
        reset_dut();
        wait_fetch_start();
        cycles = 0;
        limit = prog.size() + 20;
        while (exp_pc.size() > 0 || pc_hist.size() < prog.size() + 4) begin
            if (cycles == limit) begin
                $display("%s timed out waiting for retirements", name);
                abort_run();
            end
            check_flag(inst_en, 1'b1, {name, " inst_en while running"});
            check_word(inst_addr, word_t'(4 * pc_hist.size()), {name, " fetch address"});
            pc_hist.push_back(inst_addr);
            if (retire_we) begin
                if (exp_pc.size() == 0) begin
                    $display("%s retired pc %h with no retirement expected", name, retire_pc);
                    abort_run();
                end
                if (pc_hist.size() < 4) begin
                    $display("%s retired pc %h sooner than three cycles", name, retire_pc);
                    abort_run();
                end
                check_word(retire_pc, pc_hist[pc_hist.size() - 4], {name, " retire latency"});
                check_word(retire_pc, exp_pc.pop_front(), {name, " retire pc"});
                check_reg_addr(retire_addr, exp_rd.pop_front(), {name, " retire rd"});
                check_word(retire_data, exp_val.pop_front(), {name, " retire value"});
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic test_reset_and_fetch();
        prog.delete();
        prog.push_back('0);
        prog.push_back('0);
        prog.push_back(enc_i(`F3_ADD, 5'd1, 5'd0, 12'd5));
        prog.push_back('0);
        run_program("reset_fetch");
    endtask

    task automatic test_imm_ops();
        prog.delete();
        prog.push_back(enc_i(`F3_ADD, 5'd1, 5'd0, 12'd100));
        // x2 = -7
        prog.push_back(enc_i(`F3_ADD, 5'd2, 5'd0, 12'hff9));
        prog.push_back(enc_i(`F3_SLT, 5'd3, 5'd2, 12'hffd));
        prog.push_back(enc_i(`F3_SLT, 5'd4, 5'd2, 12'hff8));
        prog.push_back(enc_i(`F3_SLTU, 5'd5, 5'd2, 12'hfff));
        prog.push_back(enc_i(`F3_SLTU, 5'd6, 5'd1, 12'd5));
        prog.push_back(enc_i(`F3_XOR, 5'd7, 5'd2, 12'hfff));
        prog.push_back(enc_i(`F3_OR, 5'd8, 5'd1, 12'h0f0));
        prog.push_back(enc_i(`F3_AND, 5'd9, 5'd2, 12'h7ff));
        prog.push_back(enc_i(`F3_SLL, 5'd10, 5'd2, {7'h00, 5'd4}));
        prog.push_back(enc_i(`F3_SR, 5'd11, 5'd2, {7'h00, 5'd28}));
        prog.push_back(enc_i(`F3_SR, 5'd12, 5'd2, {7'h20, 5'd2}));
        prog.push_back(enc_i(`F3_ADD, 5'd13, 5'd1, 12'h800));
        run_program("imm_ops");
    endtask

    task automatic test_reg_ops();
        prog.delete();
        prog.push_back(enc_i(`F3_ADD, 5'd1, 5'd0, 12'hffb));
        prog.push_back(enc_i(`F3_ADD, 5'd2, 5'd0, 12'd3));
        prog.push_back(enc_i(`F3_ADD, 5'd3, 5'd0, 12'h7ff));
        prog.push_back(enc_r(7'h00, `F3_ADD, 5'd4, 5'd1, 5'd3));
        prog.push_back(enc_r(7'h20, `F3_ADD, 5'd5, 5'd2, 5'd3));
        prog.push_back(enc_r(7'h00, `F3_SLL, 5'd6, 5'd3, 5'd2));
        prog.push_back(enc_r(7'h00, `F3_SLT, 5'd7, 5'd1, 5'd2));
        prog.push_back(enc_r(7'h00, `F3_SLTU, 5'd8, 5'd1, 5'd2));
        prog.push_back(enc_r(7'h00, `F3_SLT, 5'd9, 5'd2, 5'd1));
        prog.push_back(enc_r(7'h00, `F3_SLTU, 5'd10, 5'd2, 5'd1));
        prog.push_back(enc_r(7'h00, `F3_XOR, 5'd11, 5'd1, 5'd3));
        prog.push_back(enc_r(7'h00, `F3_SR, 5'd12, 5'd1, 5'd2));
        prog.push_back(enc_r(7'h20, `F3_SR, 5'd13, 5'd1, 5'd2));
        prog.push_back(enc_r(7'h00, `F3_OR, 5'd14, 5'd1, 5'd3));
        prog.push_back(enc_r(7'h00, `F3_AND, 5'd15, 5'd1, 5'd3));
        run_program("reg_ops");
    endtask

    task automatic test_forwarding();
        prog.delete();
        prog.push_back(enc_i(`F3_ADD, 5'd1, 5'd0, 12'd1));
        prog.push_back(enc_r(7'h00, `F3_ADD, 5'd1, 5'd1, 5'd1));
        prog.push_back(enc_r(7'h00, `F3_ADD, 5'd1, 5'd1, 5'd1));
        prog.push_back(enc_i(`F3_ADD, 5'd2, 5'd1, 12'd3));
        prog.push_back(enc_i(`F3_ADD, 5'd3, 5'd0, 12'd10));
        prog.push_back(enc_i(`F3_ADD, 5'd4, 5'd0, 12'd20));
        prog.push_back(enc_r(7'h00, `F3_ADD, 5'd5, 5'd3, 5'd4));
        prog.push_back(enc_r(7'h20, `F3_ADD, 5'd6, 5'd5, 5'd5));
        prog.push_back(enc_r(7'h00, `F3_ADD, 5'd7, 5'd5, 5'd6));
        prog.push_back(enc_r(7'h00, `F3_XOR, 5'd8, 5'd7, 5'd7));
        // same register in execute and writeback, the younger value must win
        prog.push_back(enc_i(`F3_ADD, 5'd10, 5'd0, 12'd1));
        prog.push_back(enc_i(`F3_ADD, 5'd10, 5'd0, 12'd2));
        prog.push_back(enc_r(7'h00, `F3_ADD, 5'd11, 5'd10, 5'd0));
        prog.push_back(enc_r(7'h00, `F3_OR, 5'd12, 5'd11, 5'd10));
        run_program("forwarding");
    endtask

    task automatic test_bubbles();
        prog.delete();
        prog.push_back(enc_i(`F3_ADD, 5'd1, 5'd0, 12'd42));
        prog.push_back('0);
        // lw x5, 0(x0) is outside the supported set
        prog.push_back(32'h0000_2283);
        prog.push_back(enc_r(7'h01, `F3_ADD, 5'd6, 5'd1, 5'd1));
        prog.push_back(enc_i(`F3_SLL, 5'd6, 5'd1, {7'h20, 5'd1}));
        prog.push_back(enc_i(`F3_ADD, 5'd0, 5'd1, 12'd5));
        prog.push_back(enc_r(7'h00, `F3_ADD, 5'd0, 5'd1, 5'd1));
        prog.push_back(enc_r(7'h00, `F3_ADD, 5'd7, 5'd0, 5'd1));
        prog.push_back(enc_r(7'h00, `F3_OR, 5'd8, 5'd0, 5'd0));
        prog.push_back(enc_r(7'h00, `F3_ADD, 5'd9, 5'd5, 5'd6));
        run_program("bubbles");
    endtask

    function automatic word_t random_inst();
        int          kind;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm;
        kind = int'(rand_bits(5)) % 19;
        rd   = reg_addr_t'(rand_bits(5));
        rs1  = reg_addr_t'(rand_bits(5));
        rs2  = reg_addr_t'(rand_bits(5));
        imm  = 12'(rand_bits(12));
        case (kind)
            0:       return enc_i(`F3_ADD, rd, rs1, imm);
            1:       return enc_i(`F3_SLT, rd, rs1, imm);
            2:       return enc_i(`F3_SLTU, rd, rs1, imm);
            3:       return enc_i(`F3_XOR, rd, rs1, imm);
            4:       return enc_i(`F3_OR, rd, rs1, imm);
            5:       return enc_i(`F3_AND, rd, rs1, imm);
            6:       return enc_i(`F3_SLL, rd, rs1, {7'h00, imm[4:0]});
            7:       return enc_i(`F3_SR, rd, rs1, {7'h00, imm[4:0]});
            8:       return enc_i(`F3_SR, rd, rs1, {7'h20, imm[4:0]});
            9:       return enc_r(7'h00, `F3_ADD, rd, rs1, rs2);
            10:      return enc_r(7'h20, `F3_ADD, rd, rs1, rs2);
            11:      return enc_r(7'h00, `F3_SLL, rd, rs1, rs2);
            12:      return enc_r(7'h00, `F3_SLT, rd, rs1, rs2);
            13:      return enc_r(7'h00, `F3_SLTU, rd, rs1, rs2);
            14:      return enc_r(7'h00, `F3_XOR, rd, rs1, rs2);
            15:      return enc_r(7'h00, `F3_SR, rd, rs1, rs2);
            16:      return enc_r(7'h20, `F3_SR, rd, rs1, rs2);
            17:      return enc_r(7'h00, `F3_OR, rd, rs1, rs2);
            default: return enc_r(7'h00, `F3_AND, rd, rs1, rs2);
        endcase
    endfunction

    task automatic test_random();
        prog.delete();
        for (int i = 0; i < 200; i++) begin
            prog.push_back(random_inst());
        end
        run_program("random");
    endtask

    initial begin
        rst  = 1'b1;
        lfsr = 32'h5182;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
        end
        test_reset_and_fetch();
        test_imm_ops();
        test_reg_ops();
        test_forwarding();
        test_bubbles();
        test_random();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/cpu_top.sv
verification/cpu_tb.sv

// ==== Makefile ====
# Verilator simulation of the RV32I pipeline testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SRCS := $(shell grep '\.sv$$' $(FILELIST))
HDRS := $(wildcard hdl/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, whatever the binary's exit status was
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
